//--- hdl/ccm_pkg.sv
////////////////////
// Shared types for the ICCM and DCCM memory model.
// Word, per-bank request, injection mode and corruption kind.
// Referenced everywhere by scoped names.
////////////////////

`default_nettype none

package ccm_pkg;

    // Stored word is 32 data bits plus 7 check bits
    localparam int CCM_WORD_W = 39;

    // Address field sized for the deepest bank allowed
    localparam int CCM_ADDR_W = 15;

    typedef logic [CCM_WORD_W-1:0] ccm_word_t;

    // The 56-bit request one requester drives into one bank
    typedef struct packed {
        logic                  clken;
        logic                  wren;
        logic [CCM_ADDR_W-1:0] addr;
        ccm_word_t             wdata;
    } ccm_bank_req_t;

    // Bit 0 is ICCM single, bit 3 is DCCM double
    typedef struct packed {
        logic dccm_double;
        logic dccm_single;
        logic iccm_double;
        logic iccm_single;
    } ccm_inj_mode_t;

    // Corruption applied to a region's writes
    typedef enum logic [1:0] {
        FLIP_NONE   = 2'd0,
        FLIP_SINGLE = 2'd1,
        FLIP_DOUBLE = 2'd2
    } flip_kind_e;

endpackage

`default_nettype wire

//--- hdl/ccm_sram_bank.sv
////////////////////
// Generic single-port SRAM bank of 39-bit words.
// Writes land on the clock edge, reads appear on dout one cycle later
// and hold until the next read.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ccm_sram_bank #(
    parameter int INDEX_BITS = 6
) (
    input  logic                      el2_mem_export,
    input  logic                      rst_n,
    input  logic                      clken,
    input  logic                      wren,
    input  logic [INDEX_BITS-1:0]     addr,
    input  ccm_pkg::ccm_word_t        wdata,
    output ccm_pkg::ccm_word_t        dout
);

    localparam int DEPTH = 1 << INDEX_BITS;

    ccm_pkg::ccm_word_t mem [DEPTH];

    logic wr_en;
    logic rd_en;

    assign wr_en = clken & wren;
    assign rd_en = clken & ~wren;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge el2_mem_export) begin
        if (wr_en) begin
            mem[addr] <= wdata;
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    // Only a read updates dout, a write leaves it alone
    always_ff @(posedge el2_mem_export or negedge rst_n) begin
        if (!rst_n) begin
            dout <= '0;
        end else if (rd_en) begin
            dout <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/flip_mask_gen.sv
////////////////////
// Corruption mask source for one memory region.
// A seeded 32-bit Galois LFSR gives each bank a corrupt decision and
// one or two distinct bit positions; masks are combinational.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module flip_mask_gen #(
    parameter int          NUM_BANKS = 4,
    parameter logic [31:0] LFSR_SEED = 32'h0000_0001
) (
    input  logic                    el2_mem_export,
    input  logic                    rst_n,
    input  ccm_pkg::flip_kind_e     kind,
    input  logic [NUM_BANKS-1:0]    bank_wr,
    output ccm_pkg::ccm_word_t      mask [NUM_BANKS]
);

    localparam int          POS_W   = $clog2(ccm_pkg::CCM_WORD_W);
    localparam logic [31:0] LFSR_FB = 32'hB4BC_D35C;

    logic [31:0] lfsr;
    logic [31:0] lfsr_next;
    logic [63:0] lfsr_dbl;
    logic        lfsr_step;

    ////////////////////
    // LFSR
    ////////////////////

    assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? LFSR_FB : 32'h0);

    // Step only on writes that may be corrupted
    assign lfsr_step = (kind != ccm_pkg::FLIP_NONE) && (|bank_wr);

    always_ff @(posedge el2_mem_export or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= LFSR_SEED;
        end else if (lfsr_step) begin
            lfsr <= lfsr_next;
        end
    end

    // Doubled copy so each bank can take a rotated window
    assign lfsr_dbl = {lfsr, lfsr};

    ////////////////////
    // Per-bank masks
    ////////////////////

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        localparam int ROT = (b * 7) % 32;

        logic [16:0]        win;
        logic               decide;
        logic [POS_W-1:0]   pos_a;
        logic [POS_W-1:0]   off;
        logic [POS_W:0]     pos_sum;
        logic [POS_W-1:0]   pos_b;
        ccm_pkg::ccm_word_t bank_mask;

        assign win    = lfsr_dbl[ROT +: 17];
        assign decide = win[0];

        // First position in 0..38, offset in 1..38 so the second never lands on it
        assign pos_a   = POS_W'(win[8:1] % ccm_pkg::CCM_WORD_W);
        assign off     = POS_W'(win[16:9] % (ccm_pkg::CCM_WORD_W - 1)) + POS_W'(1);
        assign pos_sum = {1'b0, pos_a} + {1'b0, off};
        assign pos_b   = (pos_sum >= (POS_W+1)'(ccm_pkg::CCM_WORD_W)) ?
                         POS_W'(pos_sum - (POS_W+1)'(ccm_pkg::CCM_WORD_W)) :
                         pos_sum[POS_W-1:0];

        always_comb begin
            bank_mask = '0;
            if (bank_wr[b] && decide) begin
                case (kind)
                    ccm_pkg::FLIP_SINGLE: begin
                        bank_mask[pos_a] = 1'b1;
                    end
                    ccm_pkg::FLIP_DOUBLE: begin
                        bank_mask[pos_a] = 1'b1;
                        bank_mask[pos_b] = 1'b1;
                    end
                    default: begin
                        bank_mask = '0;
                    end
                endcase
            end
        end

        assign mask[b] = bank_mask;
    end

endmodule

`default_nettype wire

//--- hdl/ccm_region.sv
////////////////////
// One closely coupled memory region (ICCM or DCCM).
// Holds NUM_BANKS banks and corrupts their write data with the masks
// from its own generator; reads pass straight out of the banks.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ccm_region #(
    parameter int          NUM_BANKS  = 4,
    parameter int          INDEX_BITS = 6,
    parameter logic [31:0] LFSR_SEED  = 32'h0000_0001
) (
    input  logic                    el2_mem_export,
    input  logic                    rst_n,
    input  ccm_pkg::flip_kind_e     kind,
    input  ccm_pkg::ccm_bank_req_t  req  [NUM_BANKS],
    output ccm_pkg::ccm_word_t      dout [NUM_BANKS]
);

    logic [NUM_BANKS-1:0] bank_wr;
    ccm_pkg::ccm_word_t   wr_mask    [NUM_BANKS];
    ccm_pkg::ccm_word_t   bank_wdata [NUM_BANKS];

    ////////////////////
    // Mask generator
    ////////////////////

    flip_mask_gen #(
        .NUM_BANKS (NUM_BANKS),
        .LFSR_SEED (LFSR_SEED)
    ) u_mask_gen (
        .el2_mem_export (el2_mem_export),
        .rst_n          (rst_n),
        .kind           (kind),
        .bank_wr        (bank_wr),
        .mask           (wr_mask)
    );

    ////////////////////
    // Banks
    ////////////////////

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        // Write strobe for this bank
        assign bank_wr[b] = req[b].clken & req[b].wren;

        // Mask is zero unless this bank writes, so reads are untouched
        assign bank_wdata[b] = req[b].wdata ^ wr_mask[b];

        ccm_sram_bank #(
            .INDEX_BITS (INDEX_BITS)
        ) u_bank (
            .el2_mem_export (el2_mem_export),
            .rst_n          (rst_n),
            .clken          (req[b].clken),
            .wren           (req[b].wren),
            .addr           (req[b].addr[INDEX_BITS-1:0]),
            .wdata          (bank_wdata[b]),
            .dout           (dout[b])
        );
    end

endmodule

`default_nettype wire

//--- hdl/ccm_sram_export.sv
////////////////////
// Top of the ICCM and DCCM memory model.
// Decodes the injection mode per region and sets bank count, depth
// and LFSR seed for both regions.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ccm_sram_export #(
    parameter int          ICCM_BANKS      = 4,
    parameter int          ICCM_INDEX_BITS = 6,
    parameter int          DCCM_BANKS      = 4,
    parameter int          DCCM_INDEX_BITS = 6,
    parameter logic [31:0] ICCM_LFSR_SEED  = 32'h1D87_2B41,
    parameter logic [31:0] DCCM_LFSR_SEED  = 32'h6A3C_E915
) (
    input  logic                    el2_mem_export,
    input  logic                    rst_n,
    input  ccm_pkg::ccm_inj_mode_t  inj_mode,
    input  ccm_pkg::ccm_bank_req_t  iccm_req  [ICCM_BANKS],
    output ccm_pkg::ccm_word_t      iccm_dout [ICCM_BANKS],
    input  ccm_pkg::ccm_bank_req_t  dccm_req  [DCCM_BANKS],
    output ccm_pkg::ccm_word_t      dccm_dout [DCCM_BANKS]
);

    ccm_pkg::flip_kind_e iccm_kind;
    ccm_pkg::flip_kind_e dccm_kind;

    // Double wins when both bits of a region are set
    assign iccm_kind = inj_mode.iccm_double ? ccm_pkg::FLIP_DOUBLE :
                       inj_mode.iccm_single ? ccm_pkg::FLIP_SINGLE : ccm_pkg::FLIP_NONE;
    assign dccm_kind = inj_mode.dccm_double ? ccm_pkg::FLIP_DOUBLE :
                       inj_mode.dccm_single ? ccm_pkg::FLIP_SINGLE : ccm_pkg::FLIP_NONE;

    ccm_region #(
        .NUM_BANKS  (ICCM_BANKS),
        .INDEX_BITS (ICCM_INDEX_BITS),
        .LFSR_SEED  (ICCM_LFSR_SEED)
    ) u_iccm (
        .el2_mem_export (el2_mem_export),
        .rst_n          (rst_n),
        .kind           (iccm_kind),
        .req            (iccm_req),
        .dout           (iccm_dout)
    );

    ccm_region #(
        .NUM_BANKS  (DCCM_BANKS),
        .INDEX_BITS (DCCM_INDEX_BITS),
        .LFSR_SEED  (DCCM_LFSR_SEED)
    ) u_dccm (
        .el2_mem_export (el2_mem_export),
        .rst_n          (rst_n),
        .kind           (dccm_kind),
        .req            (dccm_req),
        .dout           (dccm_dout)
    );

endmodule

`default_nettype wire

//--- bench/ccm_tb.sv
////////////////////
// Directed testbench for the ICCM and DCCM memory model.
// Keeps a shadow copy of every written word and checks reads, read timing
// and write corruption against it.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ccm_tb;

    localparam int NUM_BANKS  = 4;
    localparam int DEPTH      = 64;
    localparam int MAX_CYCLES = 4000;

    logic                   el2_mem_export;
    logic                   rst_n;
    ccm_pkg::ccm_inj_mode_t inj_mode;
    ccm_pkg::ccm_bank_req_t iccm_req  [NUM_BANKS];
    ccm_pkg::ccm_word_t     iccm_dout [NUM_BANKS];
    ccm_pkg::ccm_bank_req_t dccm_req  [NUM_BANKS];
    ccm_pkg::ccm_word_t     dccm_dout [NUM_BANKS];

    // Shadow of what the testbench wrote, and the last words read back
    ccm_pkg::ccm_word_t iccm_mem [NUM_BANKS][DEPTH];
    ccm_pkg::ccm_word_t dccm_mem [NUM_BANKS][DEPTH];
    ccm_pkg::ccm_word_t iccm_rd  [NUM_BANKS];
    ccm_pkg::ccm_word_t dccm_rd  [NUM_BANKS];

    integer seed;
    int     cycle_count = 0;

    ccm_sram_export i_ccm_sram_export (
        .el2_mem_export (el2_mem_export),
        .rst_n          (rst_n),
        .inj_mode       (inj_mode),
        .iccm_req       (iccm_req),
        .iccm_dout      (iccm_dout),
        .dccm_req       (dccm_req),
        .dccm_dout      (dccm_dout)
    );

    initial begin
        el2_mem_export = 1'b0;
        forever #10 el2_mem_export = ~el2_mem_export;
    end

    always @(posedge el2_mem_export) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("Test FAILED");
            $fatal(1, "Run did not finish in time");
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    function automatic int popcount(input ccm_pkg::ccm_word_t v);
        int n;
        n = 0;
        for (int i = 0; i < ccm_pkg::CCM_WORD_W; i++) begin
            n += v[i];
        end
        return n;
    endfunction

    function automatic ccm_pkg::ccm_word_t rand_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[ccm_pkg::CCM_WORD_W-1:0];
    endfunction

    task automatic clear_reqs();
        for (int b = 0; b < NUM_BANKS; b++) begin
            iccm_req[b] = '0;
            dccm_req[b] = '0;
        end
    endtask

    task automatic set_write(input bit is_dccm, input int bank, input int addr,
                             input ccm_pkg::ccm_word_t data);
        ccm_pkg::ccm_bank_req_t r;
        r.clken = 1'b1;
        r.wren  = 1'b1;
        r.addr  = ccm_pkg::CCM_ADDR_W'(addr);
        r.wdata = data;
        if (is_dccm) begin
            dccm_req[bank]       = r;
            dccm_mem[bank][addr] = data;
        end else begin
            iccm_req[bank]       = r;
            iccm_mem[bank][addr] = data;
        end
    endtask

    task automatic set_read(input bit is_dccm, input int bank, input int addr);
        ccm_pkg::ccm_bank_req_t r;
        r       = '0;
        r.clken = 1'b1;
        r.addr  = ccm_pkg::CCM_ADDR_W'(addr);
        if (is_dccm) begin
            dccm_req[bank] = r;
        end else begin
            iccm_req[bank] = r;
        end
    endtask

    // All banks of both regions write in the same cycle, one row per cycle
    task automatic write_rows(input int first, input int last);
        for (int a = first; a <= last; a++) begin
            @(negedge el2_mem_export);
            for (int b = 0; b < NUM_BANKS; b++) begin
                set_write(1'b0, b, a, rand_word());
                set_write(1'b1, b, a, rand_word());
            end
        end
        @(negedge el2_mem_export);
        clear_reqs();
    endtask

    task automatic read_row(input int addr);
        @(negedge el2_mem_export);
        for (int b = 0; b < NUM_BANKS; b++) begin
            set_read(1'b0, b, addr);
            set_read(1'b1, b, addr);
        end
        @(negedge el2_mem_export);
        clear_reqs();
        iccm_rd = iccm_dout;
        dccm_rd = dccm_dout;
    endtask

    // flips of zero demands an exact word, else the word differs in 0 or flips bits
    task automatic compare_word(input string name, input ccm_pkg::ccm_word_t expected,
                                input ccm_pkg::ccm_word_t actual, input int flips,
                                inout int diffs);
        int pc;
        pc = popcount(expected ^ actual);
        if (flips == 0) begin
            check(name, expected, actual);
        end else begin
            check(name, (pc == 0) ? 0 : flips, pc);
        end
        if (pc != 0) begin
            diffs++;
        end
    endtask

    task automatic check_rows(input string name, input int first, input int last,
                              input int iccm_flips, input int dccm_flips,
                              output int iccm_diffs, output int dccm_diffs);
        iccm_diffs = 0;
        dccm_diffs = 0;
        for (int a = first; a <= last; a++) begin
            read_row(a);
            for (int b = 0; b < NUM_BANKS; b++) begin
                compare_word({name, " iccm"}, iccm_mem[b][a], iccm_rd[b], iccm_flips,
                             iccm_diffs);
                compare_word({name, " dccm"}, dccm_mem[b][a], dccm_rd[b], dccm_flips,
                             dccm_diffs);
            end
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_values();
        for (int b = 0; b < NUM_BANKS; b++) begin
            check("reset_values iccm", 0, iccm_dout[b]);
            check("reset_values dccm", 0, dccm_dout[b]);
        end
    endtask

    task automatic test_fill_exact();
        int idiff;
        int ddiff;
        inj_mode = '0;
        write_rows(0, DEPTH - 1);
        check_rows("fill_exact", 0, DEPTH - 1, 0, 0, idiff, ddiff);
    endtask

    task automatic test_read_timing();
        ccm_pkg::ccm_word_t held;
        @(negedge el2_mem_export);
        set_read(1'b0, 1, 10);
        @(negedge el2_mem_export);
        clear_reqs();
        check("read_timing latency", iccm_mem[1][10], iccm_dout[1]);
        held = iccm_mem[1][10];
        // Idle cycles keep the word
        repeat (3) begin
            @(negedge el2_mem_export);
            check("read_timing idle hold", held, iccm_dout[1]);
        end
        // Writes to the same bank, including the address just read
        @(negedge el2_mem_export);
        set_write(1'b0, 1, 10, rand_word());
        @(negedge el2_mem_export);
        set_write(1'b0, 1, 11, rand_word());
        @(negedge el2_mem_export);
        clear_reqs();
        check("read_timing write hold", held, iccm_dout[1]);
        set_read(1'b0, 1, 10);
        @(negedge el2_mem_export);
        clear_reqs();
        check("read_timing reread", iccm_mem[1][10], iccm_dout[1]);
    endtask

    task automatic test_iccm_single();
        int idiff;
        int ddiff;
        @(negedge el2_mem_export);
        inj_mode             = '0;
        inj_mode.iccm_single = 1'b1;
        write_rows(0, 15);
        check_rows("iccm_single", 0, 15, 1, 0, idiff, ddiff);
        check("iccm_single some word corrupted", 1, idiff > 0);
    endtask

    task automatic test_dccm_double();
        int idiff;
        int ddiff;
        @(negedge el2_mem_export);
        inj_mode             = '0;
        inj_mode.dccm_double = 1'b1;
        write_rows(16, 31);
        check_rows("dccm_double", 16, 31, 0, 2, idiff, ddiff);
        check("dccm_double some word corrupted", 1, ddiff > 0);
        // Double wins over single
        @(negedge el2_mem_export);
        inj_mode.dccm_single = 1'b1;
        write_rows(32, 47);
        check_rows("dccm_both", 32, 47, 0, 2, idiff, ddiff);
        check("dccm_both some word corrupted", 1, ddiff > 0);
    endtask

    task automatic test_clear_after_off();
        int idiff;
        int ddiff;
        @(negedge el2_mem_export);
        inj_mode = '0;
        write_rows(0, 47);
        check_rows("clear_after_off", 0, 47, 0, 0, idiff, ddiff);
    endtask

    initial begin
        seed     = 32'he5c0_d72d;
        rst_n    = 1'b0;
        inj_mode = '0;
        clear_reqs();
        repeat (5) @(posedge el2_mem_export);
        @(negedge el2_mem_export);
        rst_n = 1'b1;

        test_reset_values();
        test_fill_exact();
        test_read_timing();
        test_iccm_single();
        test_dccm_double();
        test_clear_after_off();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/ccm_pkg.sv
hdl/ccm_sram_bank.sv
hdl/flip_mask_gen.sv
hdl/ccm_region.sv
hdl/ccm_sram_export.sv
bench/ccm_tb.sv
